// File: corePkg.sv
package corePkg;

    // data word, also used for instruction words
    typedef logic [31:0] wordT;

    // program counter counts words, not bytes
    typedef logic [31:0] pcT;

    typedef logic [3:0] regIdxT;

    localparam int NumRegs = 16;

endpackage

// File: isaPkg.sv
package isaPkg;

    // major opcode in the top nibble, unlisted codes behave as no-op
    typedef enum logic [3:0] {
        OpArith  = 4'd0,
        OpArithc = 4'd1,
        OpBranch = 4'd3,
        OpJump   = 4'd4,
        OpHalt   = 4'd5
    } opcodeT;

    // result = a op b
    typedef enum logic [3:0] {
        AluAdd = 4'd0,
        AluSub = 4'd1,
        AluAnd = 4'd2,
        AluOr  = 4'd3,
        AluXor = 4'd4,
        AluShl = 4'd5,
        AluShr = 4'd6,
        AluSlt = 4'd7
    } aluOpT;

    // codes 3 and 7 are never taken
    typedef enum logic [2:0] {
        BrEq = 3'd0,
        BrGt = 3'd1,
        BrGe = 3'd2,
        BrNe = 3'd4,
        BrLt = 3'd5,
        BrLe = 3'd6
    } branchOpT;

    localparam int OpcodeHi = 31;
    localparam int OpcodeLo = 28;
    localparam int AluOpHi = 27;
    localparam int AluOpLo = 24;
    localparam int AregHi = 23;
    localparam int AregLo = 20;
    localparam int BregHi = 19;
    localparam int BregLo = 16;
    localparam int DregHi = 3;
    localparam int DregLo = 0;
    // signed constant of ARITHC
    localparam int ConstHi = 19;
    localparam int ConstLo = 4;
    localparam int BranchOpHi = 27;
    localparam int BranchOpLo = 25;
    localparam int SignedBit = 24;
    localparam int OffsetHi = 15;
    localparam int OffsetLo = 0;
    localparam int RelativeBit = 27;
    localparam int Const27Hi = 26;
    localparam int Const27Lo = 0;

endpackage

// File: instrStreamIf.sv
`timescale 1ns/1ps

// valid/ready handshake carrying one instruction and its pc
interface instrStreamIf;

    logic valid;
    logic ready;
    corePkg::wordT instr;
    corePkg::pcT pc;

    modport source
    (
        output valid, instr, pc,
        input ready
    );

    modport sink
    (
        input valid, instr, pc,
        output ready
    );

endinterface

// File: fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit
#(
    parameter corePkg::pcT ResetPc = '0
)
(
    input  logic clk,
    input  logic reset,
    instrStreamIf.source out,
    input  logic redirect,
    input  corePkg::pcT target,
    output logic wbCyc,
    output logic wbStb,
    output corePkg::pcT wbAdr,
    input  corePkg::wordT wbDatIn,
    input  logic wbAck
);

    typedef enum logic [1:0] {Idle, Bus, Discard, Hold} stateT;

    stateT state;
    corePkg::pcT pc;
    // target seen while a stale read is still on the bus
    corePkg::pcT redirPc;
    corePkg::wordT instrReg;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= Idle;
            pc <= ResetPc;
        end
        else
        begin
            case (state)
                Idle:
                begin
                    state <= Bus;
                end
                Bus:
                begin
                    if (redirect && wbAck)
                    begin
                        pc <= target;
                        state <= Idle;
                    end
                    else if (redirect)
                        state <= Discard;
                    else if (wbAck)
                        state <= Hold;
                end
                Discard:
                begin
                    // finish the stale read, then restart at the new pc
                    if (wbAck)
                    begin
                        pc <= redirPc;
                        state <= Idle;
                    end
                end
                Hold:
                begin
                    if (redirect)
                    begin
                        pc <= target;
                        state <= Bus;
                    end
                    else if (out.ready)
                    begin
                        pc <= pc + 1'b1;
                        state <= Bus;
                    end
                end
                default:
                    state <= Idle;
            endcase
        end
    end

    // payload registers, no reset needed
    always_ff @(posedge clk)
    begin
        if (redirect)
            redirPc <= target;
        if (state == Bus && wbAck)
            instrReg <= wbDatIn;
    end

    assign wbCyc = (state == Bus) || (state == Discard);
    assign wbStb = wbCyc;
    // pc only moves once the read on the bus has ended
    assign wbAdr = pc;

    assign out.valid = (state == Hold);
    assign out.instr = instrReg;
    assign out.pc = pc;

endmodule

// File: instrQueue.sv
`timescale 1ns/1ps

module instrQueue
#(
    parameter int QueueDepth = 4
)
(
    input  logic clk,
    input  logic reset,
    instrStreamIf.sink in,
    instrStreamIf.source out,
    input  logic redirect
);

    localparam int PtrW = $clog2(QueueDepth);
    localparam logic [PtrW:0] FullCount = (PtrW + 1)'(QueueDepth);

    corePkg::wordT instrMem [QueueDepth];
    corePkg::pcT pcMem [QueueDepth];
    logic [PtrW-1:0] rdPtr;
    logic [PtrW-1:0] wrPtr;
    logic [PtrW:0] count;
    logic push;
    logic pop;

    assign in.ready = (count != FullCount);
    assign out.valid = (count != '0);
    assign out.instr = instrMem[rdPtr];
    assign out.pc = pcMem[rdPtr];

    assign push = in.valid && in.ready;
    assign pop = out.valid && out.ready;

    always_ff @(posedge clk)
    begin
        // a taken branch or jump drops everything, including this cycle's push
        if (reset || redirect)
        begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end
        else
        begin
            if (push)
                wrPtr <= wrPtr + 1'b1;
            if (pop)
                rdPtr <= rdPtr + 1'b1;
            count <= count + (PtrW + 1)'(push) - (PtrW + 1)'(pop);
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            instrMem[wrPtr] <= in.instr;
            pcMem[wrPtr] <= in.pc;
        end
    end

endmodule

// File: regBank.sv
`timescale 1ns/1ps

module regBank
(
    input  logic clk,
    input  logic reset,
    input  corePkg::regIdxT addrA,
    input  corePkg::regIdxT addrB,
    output corePkg::wordT dataA,
    output corePkg::wordT dataB,
    input  logic we,
    input  corePkg::regIdxT addrD,
    input  corePkg::wordT dataD
);

    corePkg::wordT regs [corePkg::NumRegs];

    // r0 is hardwired to zero
    assign dataA = (addrA == '0) ? '0 : regs[addrA];
    assign dataB = (addrB == '0) ? '0 : regs[addrB];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < corePkg::NumRegs; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (we && addrD != '0)
            regs[addrD] <= dataD;
    end

endmodule

// File: executeUnit.sv
`timescale 1ns/1ps

module executeUnit
(
    input  logic clk,
    input  logic reset,
    instrStreamIf.sink in,
    output logic redirect,
    output corePkg::pcT target,
    output logic regWe,
    output corePkg::regIdxT regAddr,
    output corePkg::wordT regData,
    output logic halted
);

    typedef enum logic {Running, Halted} stateT;

    stateT state;
    logic accept;
    isaPkg::opcodeT opcode;
    isaPkg::aluOpT aluOp;
    isaPkg::branchOpT branchOp;
    corePkg::regIdxT areg;
    corePkg::regIdxT breg;
    corePkg::regIdxT dreg;
    corePkg::wordT constAlu;
    corePkg::wordT offset;
    corePkg::wordT const27;
    corePkg::wordT const27Ext;
    corePkg::wordT dataA;
    corePkg::wordT dataB;
    corePkg::wordT opA;
    corePkg::wordT opB;
    corePkg::wordT regB;
    corePkg::wordT aluResult;
    logic isSigned;
    logic branchTaken;
    logic writes;

    assign in.ready = (state == Running);
    assign accept = in.valid && in.ready;

    // field decode
    assign opcode = isaPkg::opcodeT'(in.instr[isaPkg::OpcodeHi:isaPkg::OpcodeLo]);
    assign aluOp = isaPkg::aluOpT'(in.instr[isaPkg::AluOpHi:isaPkg::AluOpLo]);
    assign branchOp = isaPkg::branchOpT'(in.instr[isaPkg::BranchOpHi:isaPkg::BranchOpLo]);
    assign areg = in.instr[isaPkg::AregHi:isaPkg::AregLo];
    assign breg = in.instr[isaPkg::BregHi:isaPkg::BregLo];
    assign dreg = in.instr[isaPkg::DregHi:isaPkg::DregLo];
    assign isSigned = in.instr[isaPkg::SignedBit];
    assign constAlu = corePkg::wordT'($signed(in.instr[isaPkg::ConstHi:isaPkg::ConstLo]));
    assign offset = corePkg::wordT'($signed(in.instr[isaPkg::OffsetHi:isaPkg::OffsetLo]));
    assign const27 = corePkg::wordT'(in.instr[isaPkg::Const27Hi:isaPkg::Const27Lo]);
    assign const27Ext = corePkg::wordT'($signed(in.instr[isaPkg::Const27Hi:isaPkg::Const27Lo]));

    regBank regBank_inst
    (
        .clk(clk),
        .reset(reset),
        .addrA(areg),
        .addrB(breg),
        .dataA(dataA),
        .dataB(dataB),
        .we(regWe),
        .addrD(regAddr),
        .dataD(regData)
    );

    // WB -> EX forwarding, the bank only sees the value one edge later
    assign opA = (regWe && regAddr == areg && areg != '0) ? regData : dataA;
    assign regB = (regWe && regAddr == breg && breg != '0) ? regData : dataB;
    assign opB = (opcode == isaPkg::OpArithc) ? constAlu : regB;

    always_comb
    begin
        case (aluOp)
            isaPkg::AluAdd: aluResult = opA + opB;
            isaPkg::AluSub: aluResult = opA - opB;
            isaPkg::AluAnd: aluResult = opA & opB;
            isaPkg::AluOr:  aluResult = opA | opB;
            isaPkg::AluXor: aluResult = opA ^ opB;
            isaPkg::AluShl: aluResult = opA << opB[4:0];
            isaPkg::AluShr: aluResult = opA >> opB[4:0];
            isaPkg::AluSlt: aluResult = corePkg::wordT'($signed(opA) < $signed(opB));
            default:        aluResult = '0;
        endcase
    end

    // branch compares use the register value of b, never the constant
    always_comb
    begin
        case (branchOp)
            isaPkg::BrEq: branchTaken = (opA == regB);
            isaPkg::BrNe: branchTaken = (opA != regB);
            isaPkg::BrGt: branchTaken = isSigned ? ($signed(opA) > $signed(regB)) : (opA > regB);
            isaPkg::BrGe: branchTaken = isSigned ? ($signed(opA) >= $signed(regB)) : (opA >= regB);
            isaPkg::BrLt: branchTaken = isSigned ? ($signed(opA) < $signed(regB)) : (opA < regB);
            isaPkg::BrLe: branchTaken = isSigned ? ($signed(opA) <= $signed(regB)) : (opA <= regB);
            default:      branchTaken = 1'b0;
        endcase
    end

    assign redirect = accept && ((opcode == isaPkg::OpJump)
                      || (opcode == isaPkg::OpBranch && branchTaken));

    always_comb
    begin
        if (opcode == isaPkg::OpJump)
            target = in.instr[isaPkg::RelativeBit] ? in.pc + const27Ext : const27;
        else
            target = in.pc + offset;
    end

    assign writes = (opcode == isaPkg::OpArith) || (opcode == isaPkg::OpArithc);

    // write-back register, also the trace port
    always_ff @(posedge clk)
    begin
        if (reset)
            regWe <= 1'b0;
        else
            regWe <= accept && writes && dreg != '0;
        regAddr <= dreg;
        regData <= aluResult;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= Running;
        else if (accept && opcode == isaPkg::OpHalt)
            state <= Halted;
    end

    assign halted = (state == Halted);

endmodule

// File: b32pLite.sv
`timescale 1ns/1ps

module b32pLite
#(
    parameter corePkg::pcT ResetPc = '0,
    parameter int QueueDepth = 4
)
(
    input  logic clk,
    input  logic reset,
    output logic wbCyc,
    output logic wbStb,
    output corePkg::pcT wbAdr,
    input  corePkg::wordT wbDatIn,
    input  logic wbAck,
    output logic regWe,
    output corePkg::regIdxT regAddr,
    output corePkg::wordT regData,
    output logic halted
);

    logic redirect;
    corePkg::pcT target;

    instrStreamIf fetchToQueue();
    instrStreamIf queueToExec();

    fetchUnit #(.ResetPc(ResetPc)) fetchUnit_inst
    (
        .clk(clk),
        .reset(reset),
        .out(fetchToQueue.source),
        .redirect(redirect),
        .target(target),
        .wbCyc(wbCyc),
        .wbStb(wbStb),
        .wbAdr(wbAdr),
        .wbDatIn(wbDatIn),
        .wbAck(wbAck)
    );

    instrQueue #(.QueueDepth(QueueDepth)) instrQueue_inst
    (
        .clk(clk),
        .reset(reset),
        .in(fetchToQueue.sink),
        .out(queueToExec.source),
        .redirect(redirect)
    );

    executeUnit executeUnit_inst
    (
        .clk(clk),
        .reset(reset),
        .in(queueToExec.sink),
        .redirect(redirect),
        .target(target),
        .regWe(regWe),
        .regAddr(regAddr),
        .regData(regData),
        .halted(halted)
    );

endmodule

// File: tbClock.sv
`timescale 1ns/1ps

// free-running clock plus a power-on reset
module tbClock
#(
    parameter int Period = 40,
    parameter int ResetCycles = 3
)
(
    output logic clk,
    output logic reset
);

    initial
    begin
        clk = 1'b0;
        forever #(Period / 2) clk = ~clk;
    end

    initial
    begin
        reset = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        #2;
        reset = 1'b0;
    end

endmodule

// File: coreChecker.sv
`timescale 1ns/1ps

// watches the trace port and compares each write with the expected list
module coreChecker
(
    input logic clk,
    input logic reset,
    input logic regWe,
    input corePkg::regIdxT regAddr,
    input corePkg::wordT regData,
    input logic halted
);

    corePkg::regIdxT expAddr [$];
    corePkg::wordT expData [$];
    string testName;
    bit active = 1'b0;
    bit haltExpected;
    bit sawHalt;
    int writeIndex;
    int testErrors;
    int errorCount = 0;
    int passedTests = 0;
    int failedTests = 0;

    task automatic startTest(input string name, input corePkg::regIdxT addrs[$],
                             input corePkg::wordT datas[$], input bit expectHalt);
        testName = name;
        expAddr = addrs;
        expData = datas;
        haltExpected = expectHalt;
        sawHalt = 1'b0;
        writeIndex = 0;
        testErrors = 0;
        active = 1'b1;
    endtask

    task automatic countError();
        testErrors++;
        errorCount++;
    endtask

    task automatic checkWrite();
        corePkg::regIdxT addr;
        corePkg::wordT data;
        if (halted)
        begin
            $display("test %s: register write to r%0d after the core halted", testName, regAddr);
            countError();
        end
        else if (expAddr.size() == 0)
        begin
            $display("test %s: extra register write r%0d = %h", testName, regAddr, regData);
            countError();
        end
        else
        begin
            addr = expAddr.pop_front();
            data = expData.pop_front();
            if (addr != regAddr || data != regData)
            begin
                $display("** Error test %s write %0d: expected r%0d = %h, actual r%0d = %h",
                         testName, writeIndex, addr, data, regAddr, regData);
                countError();
            end
        end
        writeIndex++;
    endtask

    // sample mid-cycle, away from the edge where the trace port changes
    always @(negedge clk)
    begin
        if (active && !reset)
        begin
            if (sawHalt && !halted)
            begin
                $display("test %s: halted went low again after the core stopped", testName);
                countError();
            end
            if (regWe)
                checkWrite();
            if (halted)
                sawHalt = 1'b1;
        end
    end

    task automatic finishTest();
        active = 1'b0;
        if (expAddr.size() != 0)
        begin
            $display("test %s: %0d expected register writes never happened",
                     testName, expAddr.size());
            countError();
        end
        if (haltExpected && !sawHalt)
        begin
            $display("test %s: the core never reached halt", testName);
            countError();
        end
        if (testErrors == 0)
        begin
            passedTests++;
            $display("test %s: ok, %0d writes", testName, writeIndex);
        end
        else
        begin
            failedTests++;
            $display("test %s: failed with %0d errors", testName, testErrors);
        end
    endtask

    task automatic printCounts();
        $display("tests passed %0d, failed %0d, errors %0d", passedTests, failedTests, errorCount);
    endtask

endmodule

// File: coreTb.sv
`timescale 1ns/1ps

module coreTb;

    localparam int NumTests = 7;
    localparam int MaxLen = 160;
    localparam int RandomLen = 24;
    localparam int CyclesPerWord = 20;
    localparam int ClockPeriod = 40;
    localparam int SettleCycles = 50;
    localparam int StepLimit = 2000;
    localparam corePkg::pcT ResetPc = '0;

    logic clk;
    logic powerReset;
    logic testReset;
    logic reset;
    logic wbCyc;
    logic wbStb;
    corePkg::pcT wbAdr;
    corePkg::wordT wbDatIn;
    logic wbAck;
    logic regWe;
    corePkg::regIdxT regAddr;
    corePkg::wordT regData;
    logic halted;

    corePkg::wordT progs [NumTests][MaxLen];
    int lens [NumTests];
    string names [NumTests];
    int curTest;
    bit programsReady = 1'b0;
    bit readOpen;
    int waitLeft;

    assign reset = powerReset || testReset;

    tbClock #(.Period(ClockPeriod), .ResetCycles(3)) tbClock_inst
    (
        .clk(clk),
        .reset(powerReset)
    );

    b32pLite #(.ResetPc(ResetPc), .QueueDepth(4)) b32pLite_inst
    (
        .clk(clk),
        .reset(reset),
        .wbCyc(wbCyc),
        .wbStb(wbStb),
        .wbAdr(wbAdr),
        .wbDatIn(wbDatIn),
        .wbAck(wbAck),
        .regWe(regWe),
        .regAddr(regAddr),
        .regData(regData),
        .halted(halted)
    );

    coreChecker coreChecker_inst
    (
        .clk(clk),
        .reset(reset),
        .regWe(regWe),
        .regAddr(regAddr),
        .regData(regData),
        .halted(halted)
    );

    function automatic corePkg::wordT arithInstr(logic [3:0] op, int a, int b, int d);
        return {isaPkg::OpArith, op, a[3:0], b[3:0], 12'd0, d[3:0]};
    endfunction

    function automatic corePkg::wordT constInstr(logic [3:0] op, int a, int c, int d);
        return {isaPkg::OpArithc, op, a[3:0], c[15:0], d[3:0]};
    endfunction

    function automatic corePkg::wordT branchInstr(logic [2:0] op, logic s, int a, int b, int off);
        return {isaPkg::OpBranch, op, s, a[3:0], b[3:0], off[15:0]};
    endfunction

    function automatic corePkg::wordT jumpInstr(logic rel, int c);
        return {isaPkg::OpJump, rel, c[26:0]};
    endfunction

    function automatic corePkg::wordT haltInstr();
        return {isaPkg::OpHalt, 28'd0};
    endfunction

    task automatic appendWord(int t, corePkg::wordT w);
        progs[t][lens[t]] = w;
        lens[t]++;
    endtask

    // words past the end of a program decode as no-ops
    function automatic corePkg::wordT progWord(int t, corePkg::pcT adr);
        int idx;
        if (adr >= corePkg::pcT'(lens[t]))
            return {4'hF, adr[27:0]};
        idx = int'(adr);
        return progs[t][idx];
    endfunction

    function automatic corePkg::wordT aluRef(logic [3:0] op, corePkg::wordT a, corePkg::wordT b);
        case (op)
            isaPkg::AluAdd: return a + b;
            isaPkg::AluSub: return a - b;
            isaPkg::AluAnd: return a & b;
            isaPkg::AluOr:  return a | b;
            isaPkg::AluXor: return a ^ b;
            isaPkg::AluShl: return a << b[4:0];
            isaPkg::AluShr: return a >> b[4:0];
            isaPkg::AluSlt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:        return '0;
        endcase
    endfunction

    function automatic bit branchRef(logic [2:0] op, logic s, corePkg::wordT a, corePkg::wordT b);
        logic less;
        logic equal;
        equal = (a == b);
        less = s ? ($signed(a) < $signed(b)) : (a < b);
        case (op)
            isaPkg::BrEq: return equal;
            isaPkg::BrNe: return !equal;
            isaPkg::BrGt: return !less && !equal;
            isaPkg::BrGe: return !less;
            isaPkg::BrLt: return less;
            isaPkg::BrLe: return less || equal;
            default:      return 1'b0;
        endcase
    endfunction

    // interprets program t, returns 1 if it reaches halt
    function automatic bit runReference(int t, output corePkg::regIdxT addrs[$],
                                        output corePkg::wordT datas[$]);
        corePkg::wordT regs [corePkg::NumRegs];
        corePkg::wordT ins;
        corePkg::wordT a;
        corePkg::wordT b;
        corePkg::wordT result;
        corePkg::pcT pc;
        logic [3:0] opcode;
        logic [3:0] dreg;
        addrs.delete();
        datas.delete();
        for (int i = 0; i < corePkg::NumRegs; i++)
            regs[i] = '0;
        pc = ResetPc;
        for (int step = 0; step < StepLimit; step++)
        begin
            ins = progWord(t, pc);
            opcode = ins[isaPkg::OpcodeHi:isaPkg::OpcodeLo];
            dreg = ins[isaPkg::DregHi:isaPkg::DregLo];
            a = regs[ins[isaPkg::AregHi:isaPkg::AregLo]];
            b = regs[ins[isaPkg::BregHi:isaPkg::BregLo]];
            case (opcode)
                isaPkg::OpArith, isaPkg::OpArithc:
                begin
                    if (opcode == isaPkg::OpArithc)
                        b = {{16{ins[isaPkg::ConstHi]}}, ins[isaPkg::ConstHi:isaPkg::ConstLo]};
                    result = aluRef(ins[isaPkg::AluOpHi:isaPkg::AluOpLo], a, b);
                    // r0 stays zero and its writes never show on the trace
                    if (dreg != 4'd0)
                    begin
                        regs[dreg] = result;
                        addrs.push_back(dreg);
                        datas.push_back(result);
                    end
                    pc = pc + 32'd1;
                end
                isaPkg::OpBranch:
                begin
                    if (branchRef(ins[isaPkg::BranchOpHi:isaPkg::BranchOpLo],
                                  ins[isaPkg::SignedBit], a, b))
                        pc = pc + {{16{ins[isaPkg::OffsetHi]}}, ins[15:0]};
                    else
                        pc = pc + 32'd1;
                end
                isaPkg::OpJump:
                begin
                    if (ins[isaPkg::RelativeBit])
                        pc = pc + {{5{ins[isaPkg::Const27Hi]}}, ins[26:0]};
                    else
                        pc = {5'd0, ins[26:0]};
                end
                isaPkg::OpHalt:
                    return 1'b1;
                default:
                    pc = pc + 32'd1;
            endcase
        end
        return 1'b0;
    endfunction

    task automatic buildPrograms();
        int kind;
        int off;
        for (int t = 0; t < NumTests; t++)
            lens[t] = 0;
        // every ALU op, negative constants, shifts by register and constant
        names[0] = "alu";
        appendWord(0, constInstr(isaPkg::AluAdd, 0, 100, 1));
        appendWord(0, constInstr(isaPkg::AluAdd, 0, -7, 2));
        appendWord(0, arithInstr(isaPkg::AluSub, 1, 2, 3));
        appendWord(0, constInstr(isaPkg::AluAnd, 2, -16, 4));
        appendWord(0, constInstr(isaPkg::AluOr, 1, 240, 5));
        appendWord(0, arithInstr(isaPkg::AluXor, 2, 1, 6));
        appendWord(0, constInstr(isaPkg::AluShl, 2, 4, 7));
        appendWord(0, constInstr(isaPkg::AluShr, 2, 3, 8));
        appendWord(0, arithInstr(isaPkg::AluSlt, 2, 1, 9));
        appendWord(0, constInstr(isaPkg::AluSlt, 1, -1, 10));
        appendWord(0, arithInstr(4'd9, 1, 2, 11));
        appendWord(0, constInstr(isaPkg::AluShl, 1, 35, 12));
        appendWord(0, arithInstr(isaPkg::AluShr, 2, 7, 13));
        appendWord(0, haltInstr());
        // dependent chains and r0 as source and destination
        names[1] = "forward";
        appendWord(1, constInstr(isaPkg::AluAdd, 0, 5, 1));
        appendWord(1, arithInstr(isaPkg::AluAdd, 1, 1, 1));
        appendWord(1, constInstr(isaPkg::AluAdd, 1, 3, 1));
        appendWord(1, arithInstr(isaPkg::AluSub, 1, 0, 2));
        appendWord(1, arithInstr(isaPkg::AluXor, 2, 1, 3));
        appendWord(1, constInstr(isaPkg::AluAdd, 1, 1, 0));
        appendWord(1, arithInstr(isaPkg::AluAdd, 0, 1, 4));
        appendWord(1, arithInstr(isaPkg::AluOr, 4, 3, 5));
        appendWord(1, arithInstr(isaPkg::AluAdd, 5, 5, 5));
        appendWord(1, arithInstr(isaPkg::AluSub, 5, 4, 6));
        appendWord(1, haltInstr());
        // r1 = -1, r2 = r3 = 1, a taken branch skips the r10 increment
        names[2] = "branch";
        appendWord(2, constInstr(isaPkg::AluAdd, 0, -1, 1));
        appendWord(2, constInstr(isaPkg::AluAdd, 0, 1, 2));
        appendWord(2, constInstr(isaPkg::AluAdd, 0, 1, 3));
        for (int op = 0; op < 8; op++)
            for (int s = 0; s < 2; s++)
                for (int p = 0; p < 3; p++)
                begin
                    appendWord(2, branchInstr(op[2:0], s[0], (p == 0) ? 1 : 2,
                                              (p == 0) ? 2 : ((p == 1) ? 1 : 3), 2));
                    appendWord(2, constInstr(isaPkg::AluAdd, 10, 1, 10));
                    appendWord(2, constInstr(isaPkg::AluAdd, 11, 1, 11));
                end
        appendWord(2, haltInstr());
        // absolute jump forward, loop of three by relative jump back
        names[3] = "jump";
        appendWord(3, constInstr(isaPkg::AluAdd, 0, 3, 1));
        appendWord(3, jumpInstr(1'b0, 4));
        appendWord(3, constInstr(isaPkg::AluAdd, 0, 99, 2));
        appendWord(3, constInstr(isaPkg::AluAdd, 0, 98, 2));
        appendWord(3, constInstr(isaPkg::AluAdd, 3, 1, 3));
        appendWord(3, constInstr(isaPkg::AluSub, 1, 1, 1));
        appendWord(3, branchInstr(isaPkg::BrEq, 1'b0, 1, 0, 2));
        appendWord(3, jumpInstr(1'b1, -3));
        appendWord(3, jumpInstr(1'b1, 3));
        appendWord(3, constInstr(isaPkg::AluAdd, 0, 55, 4));
        appendWord(3, constInstr(isaPkg::AluAdd, 0, 56, 4));
        appendWord(3, constInstr(isaPkg::AluAdd, 3, 256, 5));
        appendWord(3, haltInstr());
        // random ALU ops with forward branches that never pass the halt
        for (int t = 4; t < NumTests; t++)
        begin
            names[t] = $sformatf("random%0d", t - 4);
            for (int i = 0; i < RandomLen - 1; i++)
            begin
                kind = $urandom % 4;
                if (kind == 0)
                begin
                    off = 1 + ($urandom % 3);
                    if (i + off > RandomLen - 1)
                        off = RandomLen - 1 - i;
                    appendWord(t, branchInstr(3'($urandom % 8), 1'($urandom % 2),
                                              $urandom % 8, $urandom % 8, off));
                end
                else if (kind == 1)
                    appendWord(t, arithInstr(4'($urandom % 10), $urandom % 8,
                                             $urandom % 8, $urandom % 8));
                else
                    appendWord(t, constInstr(4'($urandom % 10), $urandom % 8,
                                             $urandom, $urandom % 8));
            end
            appendWord(t, haltInstr());
        end
    endtask

    // program memory, each read is acked after 0 to 3 wait cycles
    initial
    begin
        wbAck = 1'b0;
        wbDatIn = '0;
        readOpen = 1'b0;
        waitLeft = 0;
        forever
        begin
            @(posedge clk);
            #2;
            if (reset || wbAck)
            begin
                wbAck = 1'b0;
                readOpen = 1'b0;
            end
            else if (wbCyc && wbStb)
            begin
                if (!readOpen)
                begin
                    readOpen = 1'b1;
                    waitLeft = $urandom % 4;
                end
                if (waitLeft == 0)
                begin
                    wbAck = 1'b1;
                    wbDatIn = progWord(curTest, wbAdr);
                end
                else
                    waitLeft--;
            end
        end
    end

    initial
    begin
        corePkg::regIdxT addrs [$];
        corePkg::wordT datas [$];
        bit expectHalt;
        int waited;
        testReset = 1'b0;
        curTest = 0;
        void'($urandom(22));
        buildPrograms();
        programsReady = 1'b1;
        for (int t = 0; t < NumTests; t++)
        begin
            expectHalt = runReference(t, addrs, datas);
            @(posedge clk);
            #2;
            testReset = 1'b1;
            curTest = t;
            repeat (3) @(posedge clk);
            #2;
            coreChecker_inst.startTest(names[t], addrs, datas, expectHalt);
            testReset = 1'b0;
            waited = 0;
            while (!halted && waited < lens[t] * CyclesPerWord)
            begin
                @(negedge clk);
                waited++;
            end
            // the core must stay quiet once halted
            repeat (SettleCycles) @(negedge clk);
            @(posedge clk);
            #2;
            coreChecker_inst.finishTest();
        end
        coreChecker_inst.printCounts();
        if (coreChecker_inst.failedTests == 0 && coreChecker_inst.errorCount == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

    // run limit scales with the total program length
    initial
    begin
        int limitNs;
        wait (programsReady);
        limitNs = 0;
        for (int t = 0; t < NumTests; t++)
            limitNs += lens[t] * CyclesPerWord * ClockPeriod;
        #(limitNs);
        $display("watchdog expired after %0d ns, the tests did not finish in time", limitNs);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// File: verilog.f
corePkg.sv
isaPkg.sv
instrStreamIf.sv
fetchUnit.sv
instrQueue.sv
regBank.sv
executeUnit.sv
b32pLite.sv
tbClock.sv
coreChecker.sv
coreTb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the core testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module coreTb -f verilog.f -o coreSim
./obj_dir/coreSim | tee sim.log

if grep -q ">>> FAIL" sim.log
then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation passed"
